// ==== trace_monitor_cases.txt ====
// case <name>, then c0/c1 <characters of channel 0/1>, hold <cycles with no output credit>
// r0/r1 <kind> <time> <pc> <target> <data> in hex, expected records per channel in order
case reg_and_mem_lines
c0 ^12@0000abcd: $7 <= deadbeef#
c0 ^9999@ffffffff:$9999<=00000000#
c0 ^345@00401000: *1000fff0 <= 0badf00d#
c0 ^0@12345678:*89abcdef<=   76543210#
r0 0 000c 0000abcd 00000007 deadbeef
r0 0 270f ffffffff 0000270f 00000000
r0 1 0159 00401000 1000fff0 0badf00d
r0 1 0000 12345678 89abcdef 76543210
case malformed_lines
c0 ^12@0000abc: $1 <= 00000001#
c0 ^12345@00000000: $1 <= 00000001#
c0 ^1@00000000: $1 < 00000001#
c0 ^1@0000ABCD: $1 <= 00000001#
c0 ^42@0000002a: $5 <= 00000005#
r0 0 002a 0000002a 00000005 00000005
case restart_mid_line
c1 ^77@0000aaaa: $3 <= 1^88@0000bbbb: *0000cccc <= 0000dddd#
c1 ^5@12^6@00000001: $2 <= 00000002#
r1 1 0058 0000bbbb 0000cccc 0000dddd
r1 0 0006 00000001 00000002 00000002
case both_channels
c0 ^1@00000010: $1 <= 00000011#^2@00000020: *00000100 <= 00000022#
c0 ^3@00000030: $31 <= 00000033#
c1 ^1001@80000000: $4095 <= cafef00d#^2002@80000004: *fffffffc <= 12345678#
c1 ^3003@80000008: $0 <= 00000000#
r0 0 0001 00000010 00000001 00000011
r0 1 0002 00000020 00000100 00000022
r0 0 0003 00000030 0000001f 00000033
r1 0 03e9 80000000 00000fff cafef00d
r1 1 07d2 80000004 fffffffc 12345678
r1 0 0bbb 80000008 00000000 00000000
case credits_withheld
hold 400
c0 ^10@00000100: $10 <= 000000a0#^11@00000104: $11 <= 000000a1#
c0 ^12@00000108: *00002000 <= 000000a2#^13@0000010c: $13 <= 000000a3#
c1 ^20@00000200: $20 <= 000000b0#^21@00000204: $21 <= 000000b1#
c1 ^22@00000208: *00003000 <= 000000b2#^23@0000020c: $23 <= 000000b3#
r0 0 000a 00000100 0000000a 000000a0
r0 0 000b 00000104 0000000b 000000a1
r0 1 000c 00000108 00002000 000000a2
r0 0 000d 0000010c 0000000d 000000a3
r1 0 0014 00000200 00000014 000000b0
r1 0 0015 00000204 00000015 000000b1
r1 1 0016 00000208 00003000 000000b2
r1 0 0017 0000020c 00000017 000000b3

// ==== trace_monitor.f ====
trace_pkg.sv
record_pkg.sv
credit_fifo.sv
trace_line_checker.sv
record_arbiter.sv
trace_monitor_top.sv
trace_monitor_sva.sv
trace_monitor_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module trace_monitor_tb -f trace_monitor.f

out=$(./obj_dir/Vtrace_monitor_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

// ==== trace_monitor_tb.sv ====
`timescale 1ns/1ps

module trace_monitor_tb
    import trace_pkg::*, record_pkg::*;
();

    localparam int char_depth = 8;
    localparam int rec_depth  = 4;

    logic            clk;
    logic            reset;
    logic [1:0]      char_valid;
    logic [1:0][7:0] char_data;
    logic            rec_credit;
    logic [1:0]      char_credit;
    logic            rec_valid;
    trace_record_t   rec_data;

    // cases as read from the data file
    string         case_name [$];
    string         case_txt [2][$];
    int            case_hold [$];
    trace_record_t exp_list [$];
    int            exp_case [$];

    // per channel traffic of the running case
    logic [7:0]    tx_q [2][$];
    trace_record_t exp_q [2][$];
    int            credits [2];
    int            owed;
    int            hold_left;
    string         cur_name;
    int            case_errs;

    trace_monitor_top #(
        .char_depth (char_depth),
        .rec_depth  (rec_depth)
    ) u_trace_monitor_top (
        .clk         (clk),
        .reset       (reset),
        .char_valid  (char_valid),
        .char_data   (char_data),
        .rec_credit  (rec_credit),
        .char_credit (char_credit),
        .rec_valid   (rec_valid),
        .rec_data    (rec_data)
    );

    always #5 clk = ~clk;

    function automatic string strip_eol(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == 8'h0a || t.getc(t.len() - 1) == 8'h0d)) begin
            t = t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    task automatic read_cases();
        int            fd;
        int            n;
        int            ch;
        int            hold;
        string         line;
        string         tag;
        logic [31:0]   kd;
        logic [31:0]   tm;
        logic [31:0]   pc;
        logic [31:0]   tgt;
        logic [31:0]   dat;
        trace_record_t r;
        fd = $fopen("trace_monitor_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace_monitor_cases.txt, no cases to run");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line = strip_eol(line);
            if (line.len() >= 2) begin
                tag = line.substr(0, 1);
                n   = case_name.size();
                ch  = (tag == "c1" || tag == "r1") ? 1 : 0;
                if (tag == "ca") begin
                    case_name.push_back(line.substr(5, line.len() - 1));
                    case_txt[0].push_back("");
                    case_txt[1].push_back("");
                    case_hold.push_back(0);
                end else if (tag == "c0" || tag == "c1") begin
                    case_txt[ch][n - 1] = {case_txt[ch][n - 1], line.substr(3, line.len() - 1)};
                end else if (tag == "ho") begin
                    void'($sscanf(line, "hold %d", hold));
                    case_hold[n - 1] = hold;
                end else if (tag == "r0" || tag == "r1") begin
                    void'($sscanf(line.substr(3, line.len() - 1), "%h %h %h %h %h",
                                  kd, tm, pc, tgt, dat));
                    r.chan     = chan_w'(ch);
                    r.kind     = kd[0];
                    r.time_val = tm[time_w-1:0];
                    r.pc       = pc;
                    r.target   = tgt;
                    r.data     = dat;
                    exp_list.push_back(r);
                    exp_case.push_back(n - 1);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic compare_field(input string field, input logic [31:0] want,
                                 input logic [31:0] got);
        assert (got === want) else begin
            $display("error case %s %s: expected %h actual %h", cur_name, field, want, got);
            case_errs++;
        end
    endtask

    task automatic check_record(input trace_record_t got);
        trace_record_t want;
        int            c;
        c = int'(got.chan);
        assert (exp_q[c].size() > 0) else begin
            $display("case %s: record on channel %0d that no line should have produced",
                     cur_name, c);
            case_errs++;
        end
        if (exp_q[c].size() > 0) begin
            want = exp_q[c].pop_front();
            compare_field("kind", 32'(want.kind), 32'(got.kind));
            compare_field("time", 32'(want.time_val), 32'(got.time_val));
            compare_field("pc", want.pc, got.pc);
            compare_field("target", want.target, got.target);
            compare_field("data", want.data, got.data);
        end
    endtask

    // senders send at most one character per cycle and only against a credit
    always @(negedge clk) begin
        for (int c = 0; c < 2; c++) begin
            if (char_credit[c]) begin
                credits[c]++;
            end
            if (!reset && credits[c] > 0 && tx_q[c].size() > 0 && $urandom_range(0, 3) != 0) begin
                char_data[c]  = tx_q[c].pop_front();
                char_valid[c] = 1'b1;
                credits[c]--;
            end else begin
                char_valid[c] = 1'b0;
            end
        end
    end

    // consumer frees a slot some random time after each record
    always @(negedge clk) begin
        if (reset) begin
            rec_credit = 1'b0;
        end else begin
            if (hold_left > 0) begin
                hold_left--;
                rec_credit = 1'b0;
            end else if (owed > 0 && $urandom_range(0, 2) == 0) begin
                rec_credit = 1'b1;
                owed--;
            end else begin
                rec_credit = 1'b0;
            end
            if (rec_valid) begin
                owed++;
                check_record(rec_data);
            end
        end
    end

    function automatic bit case_drained();
        return tx_q[0].size() == 0 && tx_q[1].size() == 0
            && credits[0] == char_depth && credits[1] == char_depth
            && exp_q[0].size() == 0 && exp_q[1].size() == 0
            && owed == 0 && hold_left == 0;
    endfunction

    task automatic run_case(input int k);
        @(posedge clk);
        cur_name  = case_name[k];
        case_errs = 0;
        for (int i = 0; i < exp_list.size(); i++) begin
            if (exp_case[i] == k) begin
                exp_q[exp_list[i].chan].push_back(exp_list[i]);
            end
        end
        hold_left = case_hold[k];
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < case_txt[c][k].len(); i++) begin
                tx_q[c].push_back(case_txt[c][k].getc(i));
            end
        end
        while (!case_drained()) begin
            @(posedge clk);
        end
        // room for a record that should not exist
        repeat (30) @(posedge clk);
        while (!case_drained()) begin
            @(posedge clk);
        end
    endtask

    initial begin
        int total_chars;
        int limit;
        int passed;
        int failed;
        void'($urandom(32'hd459_1db2));
        clk        = 1'b0;
        reset      = 1'b1;
        char_valid = '0;
        char_data  = '0;
        rec_credit = 1'b0;
        credits[0] = char_depth;
        credits[1] = char_depth;
        owed       = 0;
        hold_left  = 0;
        case_errs  = 0;
        cur_name   = "reset";
        passed     = 0;
        failed     = 0;
        read_cases();
        total_chars = 0;
        for (int k = 0; k < case_name.size(); k++) begin
            total_chars += case_txt[0][k].len() + case_txt[1][k].len();
        end
        limit = 40 * total_chars + 1000;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("timeout after %0d cycles, records or credits still outstanding", limit);
                $display("TB FAILED");
                $finish;
            end
        join_none
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int k = 0; k < case_name.size(); k++) begin
            run_case(k);
            if (case_errs == 0) begin
                $display("case %s: pass", cur_name);
                passed++;
            end else begin
                $display("case %s: fail with %0d errors", cur_name, case_errs);
                failed++;
            end
        end
        $display("cases %0d, passed %0d, failed %0d", case_name.size(), passed, failed);
        if (failed == 0 && case_name.size() > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== trace_monitor_sva.sv ====
`timescale 1ns/1ps

module trace_monitor_sva
    import record_pkg::*;
#(
    parameter int char_depth = 8,
    parameter int rec_depth  = 4
) (
    input logic          clk,
    input logic          reset,
    input logic [1:0]    char_valid,
    input logic [1:0]    char_credit,
    input logic          rec_valid,
    input logic          rec_credit,
    input logic [1:0]    rec_pending,
    input logic [1:0]    rec_grant,
    input trace_record_t rec_out [2]
);

    // credits the sender holds, and free slots at the consumer
    int char_avail [2];
    int rec_avail;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < 2; c++) begin
                char_avail[c] <= char_depth;
            end
            rec_avail <= rec_depth;
        end else begin
            for (int c = 0; c < 2; c++) begin
                char_avail[c] <= char_avail[c] + int'(char_credit[c]) - int'(char_valid[c]);
            end
            rec_avail <= rec_avail + int'(rec_credit) - int'(rec_valid);
        end
    end

    for (genvar c = 0; c < 2; c++) begin : g_chan
        // a credit returned this cycle may be spent in the same cycle
        a_char_credit: assert property (@(posedge clk) disable iff (reset)
            char_valid[c] |-> (char_avail[c] + int'(char_credit[c])) > 0)
            else $error("channel %0d sent a character with no credit left", c);

        a_rec_hold: assert property (@(posedge clk) disable iff (reset)
            rec_pending[c] && !rec_grant[c] |=> $stable(rec_out[c]))
            else $error("channel %0d changed its pending record before the grant", c);
    end

    a_rec_credit: assert property (@(posedge clk) disable iff (reset)
        rec_valid |-> rec_avail > 0)
        else $error("record left the queue with no consumer credit");

endmodule

bind trace_monitor_top trace_monitor_sva #(
    .char_depth (char_depth),
    .rec_depth  (rec_depth)
) u_sva (
    .clk         (clk),
    .reset       (reset),
    .char_valid  (char_valid),
    .char_credit (char_credit),
    .rec_valid   (rec_valid),
    .rec_credit  (rec_credit),
    .rec_pending (rec_pending),
    .rec_grant   (rec_grant),
    .rec_out     (rec_out)
);

// ==== trace_monitor_top.sv ====
`timescale 1ns/1ps

module trace_monitor_top
    import record_pkg::*;
#(
    parameter int char_depth = 8,
    parameter int rec_depth  = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic [1:0]      char_valid,
    input  logic [1:0][7:0] char_data,
    input  logic            rec_credit,
    output logic [1:0]      char_credit,
    output logic            rec_valid,
    output trace_record_t   rec_data
);

    localparam int n_chan = 2;

    // input FIFO to checker
    logic [n_chan-1:0]      fifo_valid;
    logic [n_chan-1:0][7:0] fifo_data;
    logic [n_chan-1:0]      pop;

    // checker to arbiter
    logic [n_chan-1:0]      rec_pending;
    logic [n_chan-1:0]      rec_grant;
    trace_record_t          rec_out [n_chan];

    // arbiter to record queue
    logic                   q_push;
    logic                   q_full;
    trace_record_t          q_data;

    for (genvar c = 0; c < n_chan; c++) begin : g_chan
        credit_fifo #(
            .payload_t (logic [7:0]),
            .depth     (char_depth),
            .counted   (1'b0)
        ) u_char_fifo (
            .clk        (clk),
            .reset      (reset),
            .push       (char_valid[c]),
            .push_data  (char_data[c]),
            .out_credit (pop[c]),
            .out_valid  (fifo_valid[c]),
            .out_data   (fifo_data[c]),
            .in_credit  (char_credit[c]),
            .full       ()
        );

        trace_line_checker #(
            .chan (chan_w'(c))
        ) u_checker (
            .clk         (clk),
            .reset       (reset),
            .char_valid  (fifo_valid[c]),
            .char_data   (fifo_data[c]),
            .rec_grant   (rec_grant[c]),
            .pop         (pop[c]),
            .rec_pending (rec_pending[c]),
            .rec_out     (rec_out[c])
        );
    end

    record_arbiter #(
        .n_chan (n_chan)
    ) u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .rec_pending (rec_pending),
        .rec_in      (rec_out),
        .q_full      (q_full),
        .rec_grant   (rec_grant),
        .q_push      (q_push),
        .q_data      (q_data)
    );

    // record queue, pops against consumer credits
    credit_fifo #(
        .payload_t (trace_record_t),
        .depth     (rec_depth),
        .counted   (1'b1)
    ) u_rec_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (q_push),
        .push_data  (q_data),
        .out_credit (rec_credit),
        .out_valid  (rec_valid),
        .out_data   (rec_data),
        .in_credit  (),
        .full       (q_full)
    );

endmodule

// ==== record_arbiter.sv ====
`timescale 1ns/1ps

module record_arbiter
    import record_pkg::*;
#(
    parameter int n_chan = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [n_chan-1:0] rec_pending,
    input  trace_record_t     rec_in [n_chan],
    input  logic              q_full,
    output logic [n_chan-1:0] rec_grant,
    output logic              q_push,
    output trace_record_t     q_data
);

    localparam int iw = (n_chan > 1) ? $clog2(n_chan) : 1;

    logic [iw-1:0] last;
    logic [iw-1:0] sel;
    logic          found;

    // first pending channel after the one served last
    always_comb begin
        found = 1'b0;
        sel   = last;
        for (int i = 1; i <= n_chan; i++) begin
            if (!found && rec_pending[(int'(last) + i) % n_chan]) begin
                found = 1'b1;
                sel   = iw'((int'(last) + i) % n_chan);
            end
        end
    end

    // grant and push in the same cycle
    assign q_push = found && !q_full;
    assign q_data = rec_in[sel];

    always_comb begin
        rec_grant = '0;
        if (q_push) begin
            rec_grant[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // channel 0 goes first after reset
            last <= iw'(n_chan - 1);
        end else if (q_push) begin
            last <= sel;
        end
    end

endmodule

// ==== trace_line_checker.sv ====
`timescale 1ns/1ps

module trace_line_checker
    import trace_pkg::*, record_pkg::*;
#(
    parameter logic [chan_w-1:0] chan = '0
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          char_valid,
    input  logic [7:0]    char_data,
    input  logic          rec_grant,
    output logic          pop,
    output logic          rec_pending,
    output trace_record_t rec_out
);

    typedef enum logic [3:0] {
        st_idle,
        st_time,
        st_pc,
        st_colon,
        st_reg,
        st_reg_sp,
        st_reg_lt,
        st_reg_data,
        st_addr,
        st_mem_sp,
        st_mem_lt,
        st_mem_data
    } state_t;

    state_t            state;
    state_t            state_next;

    // digit counters per field
    logic [2:0]        cnt_time;
    logic [3:0]        cnt_pc;
    logic [2:0]        cnt_reg;
    logic [3:0]        cnt_addr;
    logic [3:0]        cnt_data;

    // captured field values
    logic [time_w-1:0] time_acc;
    logic [word_w-1:0] pc_acc;
    logic [reg_w-1:0]  reg_acc;
    logic [word_w-1:0] addr_acc;
    logic [word_w-1:0] data_acc;

    logic              take;
    logic              is_dec;
    logic              is_hex;
    logic [3:0]        nib;
    logic              dig_time;
    logic              dig_pc;
    logic              dig_reg;
    logic              dig_addr;
    logic              dig_data;
    logic              line_done;
    logic              line_kind;

    // no new character while a record waits for the arbiter
    assign take = char_valid && !rec_pending;
    assign pop  = take;

    assign is_dec = (char_data >= "0") && (char_data <= "9");
    assign is_hex = is_dec || ((char_data >= "a") && (char_data <= "f"));
    assign nib    = is_dec ? char_data[3:0] : char_data[3:0] + 4'd9;

    always_comb begin
        // anything unexpected abandons the line, ^ restarts it
        state_next = (char_data == char_start) ? st_time : st_idle;
        dig_time   = 1'b0;
        dig_pc     = 1'b0;
        dig_reg    = 1'b0;
        dig_addr   = 1'b0;
        dig_data   = 1'b0;
        line_done  = 1'b0;
        line_kind  = kind_reg;
        case (state)
            st_time: begin
                if (is_dec && cnt_time < 3'd4) begin
                    state_next = st_time;
                    dig_time   = 1'b1;
                end else if (char_data == char_at && cnt_time != 3'd0) begin
                    state_next = st_pc;
                end
            end
            st_pc: begin
                if (is_hex && cnt_pc < 4'd8) begin
                    state_next = st_pc;
                    dig_pc     = 1'b1;
                end else if (char_data == char_colon && cnt_pc == 4'd8) begin
                    state_next = st_colon;
                end
            end
            st_colon: begin
                if (char_data == char_space) begin
                    state_next = st_colon;
                end else if (char_data == char_dollar) begin
                    state_next = st_reg;
                end else if (char_data == char_star) begin
                    state_next = st_addr;
                end
            end
            st_reg: begin
                if (is_dec && cnt_reg < 3'd4) begin
                    state_next = st_reg;
                    dig_reg    = 1'b1;
                end else if (char_data == char_space && cnt_reg != 3'd0) begin
                    state_next = st_reg_sp;
                end else if (char_data == char_lt && cnt_reg != 3'd0) begin
                    state_next = st_reg_lt;
                end
            end
            st_reg_sp: begin
                if (char_data == char_space) begin
                    state_next = st_reg_sp;
                end else if (char_data == char_lt) begin
                    state_next = st_reg_lt;
                end
            end
            st_reg_lt: begin
                if (char_data == char_eq) begin
                    state_next = st_reg_data;
                end
            end
            st_addr: begin
                if (is_hex && cnt_addr < 4'd8) begin
                    state_next = st_addr;
                    dig_addr   = 1'b1;
                end else if (char_data == char_space && cnt_addr == 4'd8) begin
                    state_next = st_mem_sp;
                end else if (char_data == char_lt && cnt_addr == 4'd8) begin
                    state_next = st_mem_lt;
                end
            end
            st_mem_sp: begin
                if (char_data == char_space) begin
                    state_next = st_mem_sp;
                end else if (char_data == char_lt) begin
                    state_next = st_mem_lt;
                end
            end
            st_mem_lt: begin
                if (char_data == char_eq) begin
                    state_next = st_mem_data;
                end
            end
            st_reg_data, st_mem_data: begin
                line_kind = (state == st_mem_data) ? kind_mem : kind_reg;
                // spaces only before the first data digit
                if (char_data == char_space && cnt_data == 4'd0) begin
                    state_next = state;
                end else if (is_hex && cnt_data < 4'd8) begin
                    state_next = state;
                    dig_data   = 1'b1;
                end else if (char_data == char_hash && cnt_data == 4'd8) begin
                    state_next = st_idle;
                    line_done  = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            cnt_time    <= '0;
            cnt_pc      <= '0;
            cnt_reg     <= '0;
            cnt_addr    <= '0;
            cnt_data    <= '0;
            rec_pending <= 1'b0;
        end else begin
            if (take) begin
                state <= state_next;
                if (char_data == char_start) begin
                    cnt_time <= '0;
                    cnt_pc   <= '0;
                    cnt_reg  <= '0;
                    cnt_addr <= '0;
                    cnt_data <= '0;
                end else begin
                    if (dig_time) cnt_time <= cnt_time + 3'd1;
                    if (dig_pc)   cnt_pc   <= cnt_pc + 4'd1;
                    if (dig_reg)  cnt_reg  <= cnt_reg + 3'd1;
                    if (dig_addr) cnt_addr <= cnt_addr + 4'd1;
                    if (dig_data) cnt_data <= cnt_data + 4'd1;
                end
            end
            // held until the arbiter takes it
            if (rec_grant) begin
                rec_pending <= 1'b0;
            end else if (take && line_done) begin
                rec_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            // decimal fields accumulate in binary
            if (dig_time) begin
                time_acc <= ((cnt_time == 3'd0) ? '0 : time_acc * time_w'(10))
                            + time_w'(nib);
            end
            if (dig_reg) begin
                reg_acc <= ((cnt_reg == 3'd0) ? '0 : reg_acc * reg_w'(10))
                           + reg_w'(nib);
            end
            // hex fields shift in a nibble at a time
            if (dig_pc) begin
                pc_acc <= {pc_acc[word_w-5:0], nib};
            end
            if (dig_addr) begin
                addr_acc <= {addr_acc[word_w-5:0], nib};
            end
            if (dig_data) begin
                data_acc <= {data_acc[word_w-5:0], nib};
            end
            if (line_done) begin
                rec_out.chan     <= chan;
                rec_out.kind     <= line_kind;
                rec_out.time_val <= time_acc;
                rec_out.pc       <= pc_acc;
                rec_out.target   <= (line_kind == kind_mem) ? addr_acc : word_w'(reg_acc);
                rec_out.data     <= data_acc;
            end
        end
    end

endmodule

// ==== credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 8,
    parameter bit  counted   = 1'b1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     out_credit,
    output logic     out_valid,
    output payload_t out_data,
    output logic     in_credit,
    output logic     full
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    payload_t       mem [depth];
    logic [aw-1:0]  rd_ptr;
    logic [aw-1:0]  wr_ptr;
    logic [cw-1:0]  count;
    logic           empty;
    logic           do_pop;
    logic           do_push;

    assign empty    = (count == '0);
    assign full     = (count == cw'(depth));
    assign do_push  = push && (!full || do_pop);
    assign out_data = mem[rd_ptr];

    generate
        if (counted) begin : g_counted
            // downstream credits, one per free slot at the consumer
            logic [cw-1:0] credits;

            assign do_pop    = !empty && (credits != '0);
            assign out_valid = do_pop;

            always_ff @(posedge clk) begin
                if (reset) begin
                    credits <= cw'(depth);
                end else begin
                    case ({out_credit, do_pop})
                        2'b10:   credits <= credits + 1'b1;
                        2'b01:   credits <= credits - 1'b1;
                        default: credits <= credits;
                    endcase
                end
            end
        end else begin : g_pull
            // consumer pulls directly, out_credit acts as the pop
            assign do_pop    = !empty && out_credit;
            assign out_valid = !empty;
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back to the sender per slot freed
            in_credit <= do_pop;
        end
    end

endmodule

// ==== record_pkg.sv ====
package record_pkg;

    localparam int word_w = 32;
    localparam int chan_w = 1;

    // one record per accepted line, 112 bits
    typedef struct packed {
        logic [chan_w-1:0]            chan;
        logic                         kind;
        logic [trace_pkg::time_w-1:0] time_val;
        logic [word_w-1:0]            pc;
        // addr, or the reg number zero-extended
        logic [word_w-1:0]            target;
        logic [word_w-1:0]            data;
    } trace_record_t;

endpackage

// ==== trace_pkg.sv ====
package trace_pkg;

    // characters of a trace line
    localparam logic [7:0] char_start  = "^";
    localparam logic [7:0] char_at     = "@";
    localparam logic [7:0] char_colon  = ":";
    localparam logic [7:0] char_dollar = "$";
    localparam logic [7:0] char_star   = "*";
    localparam logic [7:0] char_lt     = "<";
    localparam logic [7:0] char_eq     = "=";
    localparam logic [7:0] char_hash   = "#";
    localparam logic [7:0] char_space  = " ";

    // record kind
    localparam logic kind_reg = 1'b0;
    localparam logic kind_mem = 1'b1;

    // up to 9999 in binary
    localparam int time_w = 14;
    localparam int reg_w  = 14;

endpackage
